// ==== calls/callRegister.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lift_config.svh"

module callRegister import liftPkg::*; (
	input logic clk,
	input logic reset,
	input floorMask_t carButton,
	input floorMask_t hallUpButton,
	input floorMask_t hallDownButton,
	input logic clearEn,
	input floorIdx_t clearFloor,
	output callSet_t pending
);

	// ##############################
	// Legal hall buttons
	// ##############################

	// No up button at the top landing and no down button at the ground
	localparam floorMask_t hallUpAllowed = ~(floorMask_t'(1) << `LIFT_TOP_FLOOR);
	localparam floorMask_t hallDownAllowed = ~floorMask_t'(1);

	floorMask_t clearMask;
	callSet_t nextPending;

	// ##############################
	// Latch and clear
	// ##############################

	always_comb begin
		if (clearEn) begin
			clearMask = floorMask_t'(1) << clearFloor;
		end else begin
			clearMask = '0;
		end
	end

	// A press at the floor being opened is already served, so the clear wins
	always_comb begin
		nextPending.carCall = (pending.carCall | carButton) & ~clearMask;
		nextPending.hallUp = (pending.hallUp | hallUpButton) & hallUpAllowed & ~clearMask;
		nextPending.hallDown = (pending.hallDown | hallDownButton) & hallDownAllowed
			& ~clearMask;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			pending <= nextPending;
		end
	end

endmodule

`default_nettype wire

// ==== common/liftPkg.sv ====
`default_nettype none

`include "lift_config.svh"

package liftPkg;

	// ##############################
	// Floors and calls
	// ##############################

	typedef logic [`LIFT_FLOOR_W-1:0] floorIdx_t;

	// One bit per landing, bit 0 is the ground floor
	typedef logic [`LIFT_NUM_FLOORS-1:0] floorMask_t;

	// Hall up at the top floor and hall down at floor 0 stay zero
	typedef struct packed {
		floorMask_t carCall;
		floorMask_t hallUp;
		floorMask_t hallDown;
	} callSet_t;

	// ##############################
	// Travel
	// ##############################

	typedef enum logic {
		dirUp   = 1'b0,
		dirDown = 1'b1
	} dir_t;

	typedef enum logic [1:0] {
		stIdle     = 2'd0,
		stDoorOpen = 2'd1,
		stMoving   = 2'd2
	} travelState_t;

	typedef struct packed {
		logic moveUp;
		logic moveDown;
		logic doorOpen;
		logic stopped;
	} motion_t;

endpackage

`default_nettype wire

// ==== common/lift_config.svh ====
`ifndef LIFT_CONFIG_SVH
`define LIFT_CONFIG_SVH

// ##############################
// Shaft geometry
// ##############################

// Number of landings served by the car
`define LIFT_NUM_FLOORS 6

// Bits needed to hold a floor index
`define LIFT_FLOOR_W 3

// Highest landing, the car never travels above it
`define LIFT_TOP_FLOOR 5

`endif

// ==== controller/requestScanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module requestScanner import liftPkg::*; (
	input callSet_t pending,
	input floorIdx_t currentFloor,
	input dir_t dir,
	output logic stopHere,
	output logic callsAhead,
	output logic callsBehind
);

	floorMask_t atMask;
	floorMask_t belowMask;
	floorMask_t aboveMask;
	floorMask_t anyCall;
	logic anyAbove;
	logic anyBelow;
	logic hereCar;
	logic hereUp;
	logic hereDown;
	logic hereInDir;
	logic hereAny;

	// ##############################
	// Position masks
	// ##############################

	always_comb begin
		atMask = floorMask_t'(1) << currentFloor;
		belowMask = atMask - 1'b1;
		aboveMask = ~(belowMask | atMask);
	end

	// ##############################
	// Calls ahead and behind
	// ##############################

	// Direction of a call does not matter for deciding where work remains
	always_comb begin
		anyCall = pending.carCall | pending.hallUp | pending.hallDown;
		anyAbove = |(anyCall & aboveMask);
		anyBelow = |(anyCall & belowMask);
		if (dir == dirUp) begin
			callsAhead = anyAbove;
			callsBehind = anyBelow;
		end else begin
			callsAhead = anyBelow;
			callsBehind = anyAbove;
		end
	end

	// ##############################
	// Stop decision
	// ##############################

	always_comb begin
		hereCar = |(pending.carCall & atMask);
		hereUp = |(pending.hallUp & atMask);
		hereDown = |(pending.hallDown & atMask);
		hereInDir = (dir == dirUp) ? hereUp : hereDown;
		hereAny = hereCar | hereUp | hereDown;
		// A hall call against the travel direction waits until nothing lies beyond it
		stopHere = hereCar | hereInDir | (hereAny & !callsAhead);
	end

endmodule

`default_nettype wire

// ==== controller/travelController.sv ====
`timescale 1ns/1ps
`default_nettype none

module travelController import liftPkg::*; (
	input logic clk,
	input logic reset,
	input logic passengerIn,
	input logic arrived,
	input logic stopHere,
	input logic callsAhead,
	input logic callsBehind,
	input floorIdx_t currentFloor,
	output logic moving,
	output dir_t moveDir,
	output logic clearEn,
	output floorIdx_t clearFloor,
	output motion_t motion
);

	travelState_t state;
	travelState_t nextState;
	dir_t dir;
	dir_t nextDir;
	motion_t nextMotion;

	assign moving = (state == stMoving);
	assign moveDir = dir;

	// Calls at this floor are served the moment the door starts to open
	assign clearEn = (state == stIdle) && stopHere;
	assign clearFloor = currentFloor;

	// ##############################
	// Next state
	// ##############################

	always_comb begin
		nextState = state;
		nextDir = dir;
		case (state)
			stIdle: begin
				if (stopHere) begin
					nextState = stDoorOpen;
				end else if (callsAhead) begin
					nextState = stMoving;
				end else if (callsBehind) begin
					nextDir = (dir == dirUp) ? dirDown : dirUp;
					nextState = stMoving;
				end
			end
			stDoorOpen: begin
				if (passengerIn) begin
					nextState = stIdle;
				end
			end
			stMoving: begin
				// Decide only once the new floor has been registered
				if (arrived && (stopHere || !callsAhead)) begin
					nextState = stIdle;
				end
			end
			default: begin
				nextState = stIdle;
			end
		endcase
	end

	// ##############################
	// Motion outputs
	// ##############################

	always_comb begin
		nextMotion.moveUp = (nextState == stMoving) && (nextDir == dirUp);
		nextMotion.moveDown = (nextState == stMoving) && (nextDir == dirDown);
		nextMotion.doorOpen = (nextState == stDoorOpen);
		nextMotion.stopped = (nextState != stMoving);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			dir <= dirUp;
			motion <= '{moveUp: 1'b0, moveDown: 1'b0, doorOpen: 1'b0, stopped: 1'b1};
		end else begin
			state <= nextState;
			dir <= nextDir;
			motion <= nextMotion;
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile the lift testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module liftTb -f src.f -o liftSim \
	&& ./obj_dir/liftSim | tee /dev/stderr | grep -q "Testbench passed" \
	&& exit 0 \
	|| { echo "Simulation did not pass" >&2; exit 1; }

// ==== sim/liftTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lift_config.svh"

module liftTb import liftPkg::*; ();

	localparam int clkPeriod = 4;
	localparam int resetCycles = 10;
	localparam int idleCycles = 20;
	localparam int numCalls = 60;
	localparam int settleCycles = 20;
	// Each call may cost a trip across all floors at up to ten cycles per floor
	localparam int watchdogNs = (numCalls * `LIFT_NUM_FLOORS * 10 + resetCycles + idleCycles
		+ settleCycles) * clkPeriod;
	localparam motion_t stoppedOnly = motion_t'(4'b0001);

	logic clk;
	logic reset;
	floorMask_t carButton;
	floorMask_t hallUpButton;
	floorMask_t hallDownButton;
	floorMask_t floorSensor;
	logic passengerIn;
	motion_t motion;
	floorIdx_t floorDisplay;

	// ##############################
	// Model state
	// ##############################

	callSet_t modelCalls;
	callSet_t pressedLast;
	callSet_t pressedBefore;
	floorIdx_t modelFloor;
	floorIdx_t arrivalFloor;
	dir_t lastDir;
	motion_t prevMotion;
	int cycle;
	int arrivalCycle;
	int shaftWait;
	int doorWait;
	int pressGap;
	int callsIssued;
	logic pressing;

	liftTop u_liftTop (
		.clk(clk),
		.reset(reset),
		.carButton(carButton),
		.hallUpButton(hallUpButton),
		.hallDownButton(hallDownButton),
		.floorSensor(floorSensor),
		.passengerIn(passengerIn),
		.motion(motion),
		.floorDisplay(floorDisplay)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic callAt(callSet_t calls, floorIdx_t f);
		return calls.carCall[f] | calls.hallUp[f] | calls.hallDown[f];
	endfunction

	// Some call waits strictly beyond floor f when travelling in direction d
	function automatic logic callsBeyond(callSet_t calls, floorIdx_t f, dir_t d);
		logic found;
		found = 1'b0;
		for (int i = 0; i < `LIFT_NUM_FLOORS; i++) begin
			if ((d == dirUp && i > int'(f)) || (d == dirDown && i < int'(f))) begin
				found = found | callAt(calls, floorIdx_t'(i));
			end
		end
		return found;
	endfunction

	function automatic callSet_t latchCalls(callSet_t calls, callSet_t presses, floorMask_t clear);
		callSet_t result;
		result.carCall = (calls.carCall | presses.carCall) & ~clear;
		result.hallUp = (calls.hallUp | presses.hallUp) & ~clear;
		result.hallDown = (calls.hallDown | presses.hallDown) & ~clear;
		// The end landings have a hall button for one direction only
		result.hallUp[`LIFT_TOP_FLOOR] = 1'b0;
		result.hallDown[0] = 1'b0;
		return result;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic checkMotion(input motion_t m);
		assert (!(m.moveUp && m.moveDown))
			else abortRun($sformatf("** Error: motion = 0x%h moves up and down at once", m));
		assert (!(m.doorOpen && (m.moveUp || m.moveDown)))
			else abortRun($sformatf("** Error: motion = 0x%h moves with the door open", m));
		assert (m.stopped == !(m.moveUp || m.moveDown))
			else abortRun($sformatf("** Error: motion = 0x%h disagrees on stopped", m));
		// The car still runs in the one cycle its arrival shows
		if (cycle != arrivalCycle) begin
			assert (!(m.moveUp && modelFloor == `LIFT_TOP_FLOOR))
				else abortRun($sformatf("** Error: motion = 0x%h at floor 0x%h", m, modelFloor));
			assert (!(m.moveDown && modelFloor == 0))
				else abortRun($sformatf("** Error: motion = 0x%h at floor 0x%h", m, modelFloor));
		end
	endtask

	// ##############################
	// One clock cycle
	// ##############################

	task automatic stepCycle();
		motion_t m;
		callSet_t oldCalls;
		callSet_t presses;
		floorMask_t clear;
		floorMask_t sensor;
		floorIdx_t f;
		floorIdx_t pressFloor;
		dir_t moveDir;
		logic moving;
		logic doorRise;
		logic hallInDir;
		logic boarded;
		// Outputs are sampled half a period after the edge that set them
		@(negedge clk);
		cycle++;
		m = motion;
		if (cycle == arrivalCycle) begin
			modelFloor = arrivalFloor;
		end
		f = modelFloor;
		moving = m.moveUp || m.moveDown;
		moveDir = m.moveDown ? dirDown : dirUp;
		checkMotion(m);
		assert (floorDisplay == modelFloor)
			else abortRun($sformatf("** Error: floorDisplay = 0x%h, expected 0x%h",
				floorDisplay, modelFloor));

		// The model calls lag the DUT by one edge, so oldCalls is what it decided on
		oldCalls = modelCalls;
		doorRise = m.doorOpen && !prevMotion.doorOpen;
		if (doorRise) begin
			assert (callAt(oldCalls, f))
				else abortRun($sformatf(
					"** Error: motion = 0x%h opened at floor 0x%h, pending = 0x%h",
					m, f, oldCalls));
		end
		if (moving && cycle == arrivalCycle + 1) begin
			hallInDir = (moveDir == dirUp) ? oldCalls.hallUp[f] : oldCalls.hallDown[f];
			assert (!oldCalls.carCall[f] && !hallInDir)
				else abortRun($sformatf(
					"** Error: motion = 0x%h passed floor 0x%h, pending = 0x%h",
					m, f, oldCalls));
		end
		if (moving && moveDir != lastDir) begin
			assert (!callsBeyond(oldCalls, f, lastDir))
				else abortRun($sformatf(
					"** Error: motion = 0x%h reversed at floor 0x%h, pending = 0x%h",
					m, f, oldCalls));
			lastDir = moveDir;
		end
		clear = doorRise ? floorMask_t'(1) << f : '0;
		modelCalls = latchCalls(oldCalls, pressedBefore, clear);
		pressedBefore = pressedLast;

		// ##############################
		// Passengers and shaft
		// ##############################

		presses = '0;
		if (pressing && callsIssued < numCalls) begin
			if (pressGap > 0) begin
				pressGap--;
			end else begin
				pressFloor = floorIdx_t'($urandom % `LIFT_NUM_FLOORS);
				case ($urandom % 3)
					0: presses.carCall[pressFloor] = 1'b1;
					1: presses.hallUp[pressFloor] = 1'b1;
					default: presses.hallDown[pressFloor] = 1'b1;
				endcase
				callsIssued++;
				pressGap = 1 + $urandom % 15;
			end
		end
		pressedLast = presses;

		sensor = '0;
		if (moving) begin
			if (shaftWait == 0) begin
				shaftWait = 3 + $urandom % 6;
			end else begin
				shaftWait--;
				if (shaftWait == 0) begin
					arrivalFloor = (moveDir == dirUp) ? f + 1'b1 : f - 1'b1;
					sensor[arrivalFloor] = 1'b1;
					arrivalCycle = cycle + 2;
				end
			end
		end else begin
			shaftWait = 0;
		end

		boarded = 1'b0;
		if (doorRise) begin
			doorWait = 2 + $urandom % 5;
		end else if (doorWait > 0) begin
			doorWait--;
			boarded = (doorWait == 0);
		end
		prevMotion = m;

		@(posedge clk);
		carButton <= presses.carCall;
		hallUpButton <= presses.hallUp;
		hallDownButton <= presses.hallDown;
		floorSensor <= sensor;
		passengerIn <= boarded;
	endtask

	initial begin
		void'($urandom(10));
		clk = 1'b0;
		reset = 1'b1;
		carButton = '0;
		hallUpButton = '0;
		hallDownButton = '0;
		floorSensor = '0;
		passengerIn = 1'b0;
		modelCalls = '0;
		pressedLast = '0;
		pressedBefore = '0;
		modelFloor = '0;
		arrivalFloor = '0;
		lastDir = dirUp;
		prevMotion = stoppedOnly;
		cycle = 0;
		arrivalCycle = -10;
		shaftWait = 0;
		doorWait = 0;
		pressGap = 0;
		callsIssued = 0;
		pressing = 1'b0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		repeat (idleCycles) begin
			stepCycle();
			assert (prevMotion == stoppedOnly)
				else abortRun($sformatf("** Error: motion = 0x%h without calls, expected 0x%h",
					prevMotion, stoppedOnly));
		end

		pressing = 1'b1;
		while (callsIssued < numCalls) begin
			stepCycle();
		end
		pressing = 1'b0;

		// Let the car work off every call still held
		while (!(modelCalls == '0 && pressedLast == '0 && pressedBefore == '0
			&& doorWait == 0 && prevMotion == stoppedOnly)) begin
			stepCycle();
		end
		repeat (settleCycles) begin
			stepCycle();
			assert (prevMotion == stoppedOnly)
				else abortRun($sformatf("** Error: motion = 0x%h after all calls, expected 0x%h",
					prevMotion, stoppedOnly));
		end
		$display("Testbench passed");
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout after %0d ns with calls still unserved", watchdogNs);
		$display("Testbench failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/liftPkg.sv
calls/callRegister.sv
verilog/floorTracker.sv
controller/requestScanner.sv
controller/travelController.sv
verilog/liftTop.sv
sim/liftTb.sv

// ==== verilog/floorTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lift_config.svh"

module floorTracker import liftPkg::*; (
	input logic clk,
	input logic reset,
	input floorMask_t floorSensor,
	input logic moving,
	input dir_t moveDir,
	output floorIdx_t currentFloor,
	output logic arrived
);

	floorIdx_t nextFloor;
	floorMask_t nextMask;
	logic atEnd;
	logic sensorHit;

	// Only the landing directly ahead of the car can produce an arrival
	always_comb begin
		if (moveDir == dirUp) begin
			nextFloor = currentFloor + 1'b1;
			atEnd = (currentFloor == `LIFT_TOP_FLOOR);
		end else begin
			nextFloor = currentFloor - 1'b1;
			atEnd = (currentFloor == '0);
		end
		nextMask = floorMask_t'(1) << nextFloor;
		sensorHit = moving && !atEnd && |(floorSensor & nextMask);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			currentFloor <= '0;
			arrived <= 1'b0;
		end else begin
			arrived <= sensorHit;
			if (sensorHit) begin
				currentFloor <= nextFloor;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/liftTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module liftTop import liftPkg::*; (
	input logic clk,
	input logic reset,
	input floorMask_t carButton,
	input floorMask_t hallUpButton,
	input floorMask_t hallDownButton,
	input floorMask_t floorSensor,
	input logic passengerIn,
	output motion_t motion,
	output floorIdx_t floorDisplay
);

	callSet_t pending;
	floorIdx_t currentFloor;
	logic arrived;
	logic moving;
	dir_t moveDir;
	logic clearEn;
	floorIdx_t clearFloor;
	logic stopHere;
	logic callsAhead;
	logic callsBehind;

	// The display simply follows the tracked position
	assign floorDisplay = currentFloor;

	callRegister u_callRegister (
		.clk(clk),
		.reset(reset),
		.carButton(carButton),
		.hallUpButton(hallUpButton),
		.hallDownButton(hallDownButton),
		.clearEn(clearEn),
		.clearFloor(clearFloor),
		.pending(pending)
	);

	floorTracker u_floorTracker (
		.clk(clk),
		.reset(reset),
		.floorSensor(floorSensor),
		.moving(moving),
		.moveDir(moveDir),
		.currentFloor(currentFloor),
		.arrived(arrived)
	);

	requestScanner u_requestScanner (
		.pending(pending),
		.currentFloor(currentFloor),
		.dir(moveDir),
		.stopHere(stopHere),
		.callsAhead(callsAhead),
		.callsBehind(callsBehind)
	);

	travelController u_travelController (
		.clk(clk),
		.reset(reset),
		.passengerIn(passengerIn),
		.arrived(arrived),
		.stopHere(stopHere),
		.callsAhead(callsAhead),
		.callsBehind(callsBehind),
		.currentFloor(currentFloor),
		.moving(moving),
		.moveDir(moveDir),
		.clearEn(clearEn),
		.clearFloor(clearFloor),
		.motion(motion)
	);

endmodule

`default_nettype wire
